// ==== Makefile ====
# Verilator simulation of the credit FIFO

.PHONY: sim clean

sim:
	verilator --binary --timing -f credit_fifo.f --top-module credit_fifo_tb \
		--Mdir obj_dir -o credit_fifo_sim
	@out="$$(./obj_dir/credit_fifo_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir

// ==== credit_fifo.f ====
+incdir+rtl
rtl/credit_fifo_pkg.sv
rtl/credit_fifo_push_ctrl.sv
rtl/credit_fifo_ram.sv
rtl/credit_fifo_pop_ctrl.sv
rtl/credit_fifo.sv
sim/credit_fifo_tb.sv

// ==== rtl/credit_fifo.sv ====
// --------------------
// Credit-flow receive FIFO top level
// Connects the input side, flop RAM and output side
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "credit_fifo_defs.svh"

module credit_fifo import credit_fifo_pkg::*; (
  input  wire logic                             clk,
  input  wire logic                             rst,

  // Push side with credit return
  input  wire push_beat_t                       push,
  input  wire logic                             push_credit_stall,
  input  wire credit_cfg_t                      credit_cfg,
  output logic                                  push_credit,
  output logic [`CREDIT_FIFO_COUNT_W-1:0]       credit_count,
  output logic [`CREDIT_FIFO_COUNT_W-1:0]       credit_available,

  // Pop side with ready/valid
  input  wire logic                             pop_ready,
  output logic                                  pop_valid,
  output logic [`CREDIT_FIFO_WIDTH-1:0]         pop_data,

  output fifo_status_t                          status
);

  ram_wr_t                         ram_wr;
  logic                            push_written;
  logic                            pop_fire;
  logic                            bypass_taken;
  logic [`CREDIT_FIFO_ADDR_W-1:0]  rd_addr;
  logic [`CREDIT_FIFO_WIDTH-1:0]   rd_data;

  // Credits and writes
  credit_fifo_push_ctrl u_push_ctrl (
    .clk               (clk),
    .rst               (rst),
    .push              (push),
    .push_credit_stall (push_credit_stall),
    .credit_cfg        (credit_cfg),
    .push_credit       (push_credit),
    .credit_count      (credit_count),
    .credit_available  (credit_available),
    .pop_fire          (pop_fire),
    .bypass_taken      (bypass_taken),
    .ram_wr            (ram_wr),
    .push_written      (push_written)
  );

  // Storage
  credit_fifo_ram u_ram (
    .clk     (clk),
    .wr      (ram_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Reads, occupancy and the bypass path, which sees the raw push beat
  credit_fifo_pop_ctrl u_pop_ctrl (
    .clk          (clk),
    .rst          (rst),
    .push         (push),
    .push_written (push_written),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .pop_ready    (pop_ready),
    .pop_valid    (pop_valid),
    .pop_data     (pop_data),
    .pop_fire     (pop_fire),
    .bypass_taken (bypass_taken),
    .status       (status)
  );

endmodule

`default_nettype wire

// ==== rtl/credit_fifo_defs.svh ====
// --------------------
// Build-time settings of the credit FIFO
// Depth, word width, derived counter widths and the bypass switch
// --------------------

`ifndef CREDIT_FIFO_DEFS_SVH
`define CREDIT_FIFO_DEFS_SVH

// Number of entries, at least 2 and a power of two so the pointers wrap
`define CREDIT_FIFO_DEPTH 4

// Width of one data word
`define CREDIT_FIFO_WIDTH 16

// Pointer width into the RAM
`define CREDIT_FIFO_ADDR_W $clog2(`CREDIT_FIFO_DEPTH)

// Width of items, slots and every credit value, large enough to hold the depth
`define CREDIT_FIFO_COUNT_W $clog2(`CREDIT_FIFO_DEPTH + 1)

// Set to 1 for push-to-pop cut-through when empty, 0 to route every word through the RAM
`define CREDIT_FIFO_BYPASS 1

`endif

// ==== rtl/credit_fifo_pkg.sv ====
// --------------------
// Shared types of the credit FIFO
// Push beat, RAM write request, occupancy flags and credit setup
// --------------------

`default_nettype none

`include "credit_fifo_defs.svh"

package credit_fifo_pkg;

  // One word offered by the sender on the push side
  typedef struct packed {
    logic                          valid;
    logic [`CREDIT_FIFO_WIDTH-1:0] data;
  } push_beat_t;

  // Single-cycle write strobe into the flop RAM
  typedef struct packed {
    logic                           en;
    logic [`CREDIT_FIFO_ADDR_W-1:0] addr;
    logic [`CREDIT_FIFO_WIDTH-1:0]  data;
  } ram_wr_t;

  // Occupancy as seen from the pop side
  typedef struct packed {
    logic [`CREDIT_FIFO_COUNT_W-1:0] items;
    logic [`CREDIT_FIFO_COUNT_W-1:0] slots;
    logic                            full;
    logic                            empty;
  } fifo_status_t;

  // Credits loaded at reset and credits kept back from the sender
  typedef struct packed {
    logic [`CREDIT_FIFO_COUNT_W-1:0] initial_credit;
    logic [`CREDIT_FIFO_COUNT_W-1:0] withhold;
  } credit_cfg_t;

endpackage

`default_nettype wire

// ==== rtl/credit_fifo_pop_ctrl.sv ====
// --------------------
// Output side of the credit FIFO
// Read pointer, occupancy count, status flags, pop handshake and bypass
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "credit_fifo_defs.svh"

module credit_fifo_pop_ctrl import credit_fifo_pkg::*; (
  input  wire logic                             clk,
  input  wire logic                             rst,

  // Push beat and write strobe from the input side
  input  wire push_beat_t                       push,
  input  wire logic                             push_written,

  // Read port of the RAM
  output logic [`CREDIT_FIFO_ADDR_W-1:0]        rd_addr,
  input  wire logic [`CREDIT_FIFO_WIDTH-1:0]    rd_data,

  // Pop interface towards the consumer
  input  wire logic                             pop_ready,
  output logic                                  pop_valid,
  output logic [`CREDIT_FIFO_WIDTH-1:0]         pop_data,

  // Feedback to the input side
  output logic                                  pop_fire,
  output logic                                  bypass_taken,

  // Occupancy flags
  output fifo_status_t                          status
);

  localparam int unsigned count_w = `CREDIT_FIFO_COUNT_W;
  localparam int unsigned addr_w  = `CREDIT_FIFO_ADDR_W;
  localparam logic [count_w-1:0] depth_count = count_w'(`CREDIT_FIFO_DEPTH);

  logic [count_w-1:0] items;
  logic [count_w-1:0] items_next;
  logic [addr_w-1:0]  rd_ptr;
  logic               bypass_hit;
  logic               ram_pop;

  // --------------------
  // Pop handshake
  // --------------------

  // Cut-through applies only when nothing older is waiting in the RAM
  assign bypass_hit = (`CREDIT_FIFO_BYPASS != 0) && (items == '0) && push.valid;

  // Stored words take priority, an empty FIFO shows the incoming push
  assign pop_valid = (items != '0) || bypass_hit;
  assign pop_data  = bypass_hit ? push.data : rd_data;
  assign pop_fire  = pop_valid && pop_ready;

  // A bypassed word that is accepted never reaches the RAM
  // If the consumer is not ready it is written and shown again from the RAM next cycle
  assign bypass_taken = bypass_hit && pop_ready;

  // Pops that drain a stored word
  assign ram_pop = pop_fire && !bypass_taken;

  // --------------------
  // Read pointer and count
  // --------------------

  assign rd_addr = rd_ptr;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (ram_pop) begin
      rd_ptr <= rd_ptr + addr_w'(1);
    end
  end

  // Occupancy follows RAM writes and RAM reads only
  always_comb begin
    case ({push_written, ram_pop})
      2'b10:   items_next = items + count_w'(1);
      2'b01:   items_next = items - count_w'(1);
      default: items_next = items;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      items <= '0;
    end else begin
      items <= items_next;
    end
  end

  // Flags are all derived from the registered count
  always_comb begin
    status.items = items;
    status.slots = depth_count - items;
    status.full  = (items == depth_count);
    status.empty = (items == '0);
  end

endmodule

`default_nettype wire

// ==== rtl/credit_fifo_push_ctrl.sv ====
// --------------------
// Input side of the credit FIFO
// Credit counter, credit return pulse, write pointer and RAM write request
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "credit_fifo_defs.svh"

module credit_fifo_push_ctrl import credit_fifo_pkg::*; (
  input  wire logic                            clk,
  input  wire logic                            rst,

  // Push interface from the sender
  input  wire push_beat_t                      push,
  input  wire logic                            push_credit_stall,
  input  wire credit_cfg_t                     credit_cfg,
  output logic                                 push_credit,
  output logic [`CREDIT_FIFO_COUNT_W-1:0]      credit_count,
  output logic [`CREDIT_FIFO_COUNT_W-1:0]      credit_available,

  // Feedback from the output side
  input  wire logic                            pop_fire,
  input  wire logic                            bypass_taken,

  // Write request into the RAM and write strobe for the output side
  output ram_wr_t                              ram_wr,
  output logic                                 push_written
);

  localparam int unsigned count_w = `CREDIT_FIFO_COUNT_W;
  localparam int unsigned addr_w  = `CREDIT_FIFO_ADDR_W;

  logic [count_w-1:0] credit_count_next;
  logic [addr_w-1:0]  wr_ptr;

  // --------------------
  // Credit counter
  // --------------------

  // The counter holds every credit the FIFO still owns
  // Some of them may be withheld, the rest can go out to the sender
  always_comb begin
    if (credit_count > credit_cfg.withhold) begin
      credit_available = credit_count - credit_cfg.withhold;
    end else begin
      credit_available = '0;
    end
  end

  // One credit leaves per cycle while any are available and the sender is not stalling us
  // Credits are held back while the counter is still being loaded
  assign push_credit = !rst && !push_credit_stall && (credit_available != '0);

  // A pop hands a slot back, an outgoing credit spends one
  // Both in the same cycle cancel out
  always_comb begin
    case ({pop_fire, push_credit})
      2'b10:   credit_count_next = credit_count + count_w'(1);
      2'b01:   credit_count_next = credit_count - count_w'(1);
      default: credit_count_next = credit_count;
    endcase
  end

  // The initial credit value is loaded for as long as reset is held
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_count <= credit_cfg.initial_credit;
    end else begin
      credit_count <= credit_count_next;
    end
  end

  // --------------------
  // Write path
  // --------------------

  // A push goes into the RAM unless the output side consumed it straight away
  assign push_written = push.valid && !bypass_taken;

  // Write pointer wraps on its own because the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (push_written) begin
      wr_ptr <= wr_ptr + addr_w'(1);
    end
  end

  // Write request is valid for exactly the cycle of the push
  always_comb begin
    ram_wr.en   = push_written;
    ram_wr.addr = wr_ptr;
    ram_wr.data = push.data;
  end

endmodule

`default_nettype wire

// ==== rtl/credit_fifo_ram.sv ====
// --------------------
// Flop RAM of the credit FIFO
// One synchronous write port and one combinational read port
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "credit_fifo_defs.svh"

module credit_fifo_ram (
  input  wire logic                             clk,

  // Write port, sampled at the rising edge
  input  wire credit_fifo_pkg::ram_wr_t         wr,

  // Read port, available in the same cycle
  input  wire logic [`CREDIT_FIFO_ADDR_W-1:0]   rd_addr,
  output logic [`CREDIT_FIFO_WIDTH-1:0]         rd_data
);

  localparam int unsigned depth = `CREDIT_FIFO_DEPTH;
  localparam int unsigned width = `CREDIT_FIFO_WIDTH;

  // --------------------
  // Storage
  // --------------------

  // One word of plain flops per entry
  logic [width-1:0] mem [depth];

  // Only the addressed entry is loaded on a write
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // --------------------
  // Read
  // --------------------

  // Asynchronous read so the word at the read pointer is visible right away
  // A word written in cycle t can be read from cycle t+1 on
  assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// ==== sim/credit_fifo_tb.sv ====
// --------------------
// Testbench for the credit FIFO
// Credit sender model, queue reference model, random traffic and watchdog
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "credit_fifo_defs.svh"

module credit_fifo_tb import credit_fifo_pkg::*; ();

  localparam int depth         = `CREDIT_FIFO_DEPTH;
  localparam int count_w       = `CREDIT_FIFO_COUNT_W;
  localparam int width         = `CREDIT_FIFO_WIDTH;
  localparam int period        = 100;
  localparam int reset_cycles  = 8;
  localparam int idle_cycles   = 12;
  localparam int random_cycles = 400;
  localparam int drain_max     = 4 * depth + 8;
  localparam int hold_cycles   = 30;
  // Four resets, the idle test, two random tests and the back-pressure test
  localparam int total_cycles  = 4 * (reset_cycles + 2) + idle_cycles
                                 + 2 * (random_cycles + drain_max) + hold_cycles + drain_max;

  logic               clk = 1'b0;
  logic               rst;
  push_beat_t         push;
  logic               push_credit_stall;
  credit_cfg_t        credit_cfg;
  logic               pop_ready;
  logic               push_credit;
  logic [count_w-1:0] credit_count;
  logic [count_w-1:0] credit_available;
  logic               pop_valid;
  logic [width-1:0]   pop_data;
  fifo_status_t       status;

  // --------------------
  // Reference state
  // --------------------

  logic [width-1:0] model_q[$];
  logic [31:0]      rng_state = 32'h397a_8e84;
  int               held;
  int               count_m;
  int               cfg_initial;
  int               cfg_withhold;
  logic             cur_push_v;
  logic             cur_ready;
  logic             cur_stall;
  logic [width-1:0] cur_data;
  logic             was_stuck;
  logic [width-1:0] stuck_data;
  int               errors;
  int               test_errors;
  int               tests_run;
  int               tests_failed;
  int               bypass_count;
  int               pushes;
  int               pops;

  initial begin
    forever #(period / 2) clk = ~clk;
  end

  credit_fifo dut (
    .clk               (clk),
    .rst               (rst),
    .push              (push),
    .push_credit_stall (push_credit_stall),
    .credit_cfg        (credit_cfg),
    .push_credit       (push_credit),
    .credit_count      (credit_count),
    .credit_available  (credit_available),
    .pop_ready         (pop_ready),
    .pop_valid         (pop_valid),
    .pop_data          (pop_data),
    .status            (status)
  );

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // True with a probability of pct percent, taken from the upper LCG bits
  function automatic logic roll(input int pct);
    logic [31:0] r;
    r = next_random();
    return int'(r[31:16] % 16'd100) < pct;
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // --------------------
  // Per-cycle model
  // --------------------

  // Runs at the falling edge, when every DUT output has settled
  task automatic check_cycle();
    int   size_before;
    int   avail;
    logic exp_credit;
    logic exp_valid;
    logic fire;
    size_before = model_q.size();
    avail = (count_m > cfg_withhold) ? count_m - cfg_withhold : 0;
    exp_credit = !cur_stall && (avail != 0);
    check_equal(32'(credit_count), count_m, "credit_count");
    check_equal(32'(credit_available), avail, "credit_available");
    check_equal(32'(push_credit), 32'(exp_credit), "push_credit");
    check_equal(32'(status.items), size_before, "items");
    check_equal(32'(status.slots), depth - size_before, "slots");
    check_equal(32'(status.full), 32'(size_before == depth), "full");
    check_equal(32'(status.empty), 32'(size_before == 0), "empty");
    // The word pushed in this cycle is owed to the consumer from now on
    if (cur_push_v) begin
      model_q.push_back(cur_data);
    end
    exp_valid = (size_before != 0) || ((`CREDIT_FIFO_BYPASS != 0) && cur_push_v);
    check_equal(32'(pop_valid), 32'(exp_valid), "pop_valid");
    if (exp_valid) begin
      check_equal(32'(pop_data), 32'(model_q[0]), "pop_data");
    end
    // Empty FIFO with a push, so the word must show up in the same cycle
    if (size_before == 0 && exp_valid) begin
      bypass_count++;
      check_equal(32'(pop_data), 32'(cur_data), "cut-through pop_data");
    end
    if (was_stuck) begin
      check_equal(32'(pop_data), 32'(stuck_data), "pop_data while stalled");
    end
    fire = exp_valid && cur_ready;
    was_stuck = exp_valid && !cur_ready;
    if (exp_valid) begin
      stuck_data = model_q[0];
    end
    if (fire) begin
      void'(model_q.pop_front());
    end
    // Transfers as the DUT shows them, balanced against the sender's pushes later
    if (pop_valid && cur_ready) begin
      pops++;
    end
    // The sender banks whatever credit the DUT hands out
    if (push_credit) begin
      held++;
    end
    count_m = count_m + int'(fire) - int'(exp_credit);
    check_equal(32'(held + model_q.size() <= cfg_initial - cfg_withhold), 1,
                "credits in flight");
  endtask

  task automatic run_cycle(input logic want_push, input logic ready, input logic stall);
    logic [31:0] r;
    @(posedge clk);
    r = next_random();
    cur_push_v = want_push && (held > 0);
    cur_data = width'(r >> 8);
    if (cur_push_v) begin
      held--;
      pushes++;
    end
    cur_ready = ready;
    cur_stall = stall;
    push.valid <= cur_push_v;
    push.data <= cur_data;
    pop_ready <= ready;
    push_credit_stall <= stall;
    @(negedge clk);
    check_cycle();
  endtask

  task automatic apply_reset(input int init, input int withhold);
    @(posedge clk);
    rst <= 1'b1;
    credit_cfg.initial_credit <= count_w'(init);
    credit_cfg.withhold <= count_w'(withhold);
    push <= '0;
    pop_ready <= 1'b0;
    push_credit_stall <= 1'b0;
    repeat (reset_cycles - 1) @(posedge clk);
    @(negedge clk);
    check_equal(32'(push_credit), 0, "push_credit in reset");
    check_equal(32'(pop_valid), 0, "pop_valid in reset");
    @(posedge clk);
    rst <= 1'b0;
    cfg_initial = init;
    cfg_withhold = withhold;
    held = 0;
    count_m = init;
    model_q.delete();
    was_stuck = 1'b0;
    cur_push_v = 1'b0;
    cur_ready = 1'b0;
    cur_stall = 1'b0;
    cur_data = '0;
    @(negedge clk);
    check_cycle();
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (model_q.size() != 0 && n < drain_max) begin
      run_cycle(1'b0, 1'b1, 1'b0);
      n++;
    end
    if (model_q.size() != 0) begin
      errors++;
      test_errors++;
      $display("drain did not empty the FIFO, %0d words remain", model_q.size());
    end
    check_equal(pops, pushes, "words popped against words pushed");
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s: %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  task automatic random_traffic(input string name, input logic use_withhold);
    int init;
    int wh;
    init = 1 + int'((next_random() >> 16) % 32'(depth));
    wh = use_withhold ? int'((next_random() >> 16) % 32'(init)) : 0;
    apply_reset(init, wh);
    repeat (random_cycles) run_cycle(roll(70), roll(60), roll(25));
    drain();
    finish_test(name);
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    rst = 1'b1;
    push = '0;
    push_credit_stall = 1'b0;
    credit_cfg = '0;
    pop_ready = 1'b0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    bypass_count = 0;
    pushes = 0;
    pops = 0;

    // All credits leave right after reset, then the line goes quiet
    apply_reset(depth, 0);
    repeat (idle_cycles) run_cycle(1'b0, 1'b0, 1'b0);
    check_equal(held, depth, "credits received after reset");
    check_equal(32'(push_credit), 0, "push_credit after credits ran out");
    finish_test("initial_credits");

    random_traffic("random_open", 1'b0);
    random_traffic("random_withhold", 1'b1);

    // Consumer stalled, so the FIFO fills and credits dry up
    apply_reset(depth, 0);
    repeat (hold_cycles) run_cycle(1'b1, 1'b0, roll(30));
    check_equal(held, 0, "sender credits under back-pressure");
    check_equal(32'(status.items), depth, "items under back-pressure");
    check_equal(32'(status.full), 1, "full under back-pressure");
    check_equal(32'(push_credit), 0, "push_credit under back-pressure");
    drain();
    if (`CREDIT_FIFO_BYPASS != 0) begin
      check_equal(32'(bypass_count > 0), 1, "cut-through cycles seen");
    end
    finish_test("backpressure");

    $display("tests %0d, failed %0d, errors %0d, words %0d, cut-through cycles %0d",
             tests_run, tests_failed, errors, pushes, bypass_count);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #((total_cycles + 200) * period);
    $display("timeout: the tests did not finish within %0d clock cycles",
             total_cycles + 200);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
